// File: Bender.yml
package:
  name: codec_cfg

sources:
  - codecCfgPkg.sv
  - cfgRom.sv
  - i2cMaster.sv
  - cfgSequencer.sv
  - wbCfgRegs.sv
  - codecCfgTop.sv
  - target: simulation
    files:
      - codecCfg_assert.sv
      - codecCfgCheck.sv
      - codecCfgTb.sv

// File: build.f
codecCfgPkg.sv
cfgRom.sv
i2cMaster.sv
cfgSequencer.sv
wbCfgRegs.sv
codecCfgTop.sv
codecCfg_assert.sv
codecCfgCheck.sv
codecCfgTb.sv

// File: cfgRom.sv
module cfgRom
(
	input  logic [3:0]             index,	// Table position from sequencer
	output codecCfgPkg::cfgWrite_t entry	// Write for that position
);
	import codecCfgPkg::*;

	logic [15:0] word;	// Register number, data bit 8, data[7:0]

	//////////////// Table ////////////////
	always_comb
	begin
		case (index)
			// Audio codec words
			4'd0:    word = 16'h0000;	// Dummy write
			4'd1:    word = 16'h001C;	// Left line in, high gain
			4'd2:    word = 16'h021C;	// Right line in, high gain
			4'd3:    word = 16'h0479;	// Left headphone 0 dB
			4'd4:    word = 16'h0679;	// Right headphone 0 dB
			4'd5:    word = 16'h0810;	// Analog path, line in to ADC
			4'd6:    word = 16'h0A04;	// Digital path, 44.1 kHz de-emphasis
			4'd7:    word = 16'h0C00;	// Power all on
			4'd8:    word = 16'h0E01;	// Left justified, slave mode
			4'd9:    word = 16'h1022;	// Normal mode 384 fs
			4'd10:   word = 16'h1201;	// Activate interface
			// Video decoder word
			4'd11:   word = 16'h1500;	// Decoder setup write
			default: word = 16'h0000;
		endcase
	end

	// Device address and byte split
	always_comb
	begin
		entry.devAddr = (index < VIDEO_FIRST) ? AUDIO_ADDR : VIDEO_ADDR;
		entry.regAddr = word[15:8];	// 7-bit reg number with data bit 8 in bit 0
		entry.regData = word[7:0];
		if (index >= LUT_SIZE)
		begin
			entry = '0;	// Past the table
		end
	end

endmodule

// File: cfgSequencer.sv
module cfgSequencer
(
	input  logic                    iCLK,
	input  logic                    iRST_N,
	input  logic                    restart,	// Accepted in SEQ_DONE only
	input  codecCfgPkg::cfgWrite_t  entry,		// From table
	output logic [3:0]              index,
	output logic                    xferStart,
	output codecCfgPkg::cfgWrite_t  xferData,
	input  codecCfgPkg::i2cResult_t result,
	output logic                    busy,
	output logic                    done,
	output logic [7:0]              nackCount,
	output logic [7:0]              failCount
);
	import codecCfgPkg::*;

	seqState_e state;
	logic [$clog2(MAX_TRIES+1)-1:0] tries;	// Failed attempts on this entry

	//////////////// Control FSM ////////////////
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			state     <= SEQ_IDLE;
			index     <= '0;
			tries     <= '0;
			xferStart <= 1'b0;
			nackCount <= '0;
			failCount <= '0;
		end
		else
		begin
			xferStart <= 1'b0;
			case (state)
				SEQ_IDLE: state <= SEQ_LOAD;	// No host wait
				SEQ_LOAD:
				begin
					if (index >= LUT_SIZE)
						state <= SEQ_DONE;
					else
					begin
						xferStart <= 1'b1;	// Master idle here
						state     <= SEQ_XFER;
					end
				end
				SEQ_XFER:
				begin
					if (result.done)
					begin
						if (!result.nack)
						begin
							tries <= '0;
							state <= SEQ_NEXT;
						end
						else
						begin
							nackCount <= nackCount + 8'd1;
							if (tries == MAX_TRIES - 1)
							begin
								failCount <= failCount + 8'd1;	// Give up
								tries     <= '0;
								state     <= SEQ_NEXT;
							end
							else
							begin
								tries <= tries + 1'b1;
								state <= SEQ_LOAD;		// Same entry again
							end
						end
					end
				end
				SEQ_NEXT:
				begin
					index <= index + 4'd1;
					state <= SEQ_LOAD;
				end
				SEQ_DONE:
				begin
					if (restart)
					begin
						index     <= '0;
						tries     <= '0;
						nackCount <= '0;
						failCount <= '0;
						state     <= SEQ_LOAD;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Entry held for the master
	always_ff @(posedge iCLK)
	begin
		if (state == SEQ_LOAD)
			xferData <= entry;
	end

	assign busy = (state != SEQ_DONE);
	assign done = (state == SEQ_DONE);

endmodule

// File: codecCfgCheck.sv
module codecCfgCheck
(
	input  logic       iCLK,
	input  logic       iRST_N,
	input  logic       scl,
	input  logic       sda,
	input  logic [3:0] onceIdx,	// NACKed on its first attempt only
	input  logic [3:0] alwaysIdx,	// NACKed on every attempt
	output logic       nackNow,	// Address NACK wanted on this attempt
	output int         xferCount,	// Transfers seen since reset
	output int         runCount,	// Complete passes through the table
	output int         errCount
);
	timeunit 1ns;
	timeprecision 1ps;
	import codecCfgPkg::*;

	logic [3:0]  curIdx;		// Entry expected next
	int          curTry;		// Attempts already made on it
	logic        prevScl;
	logic        prevSda;
	int          bitCnt;		// SCL rises since start
	logic [23:0] dataShift;	// Three payload bytes
	logic        ackHigh;		// Any ack slot left high
	cfgWrite_t   expWrite;

	assign nackNow = (curIdx == alwaysIdx) || (curIdx == onceIdx && curTry == 0);

	////////////////////////////////////////
	// Expected write per table position
	function automatic cfgWrite_t refWrite(logic [3:0] idx);
		logic [15:0] word;	// 7-bit register number, 9 data bits
		cfgWrite_t   w;
		case (idx)
			4'd0:    word = {7'd0, 9'h000};	// Dummy
			4'd1:    word = {7'd0, 9'h01C};
			4'd2:    word = {7'd1, 9'h01C};
			4'd3:    word = {7'd2, 9'h079};
			4'd4:    word = {7'd3, 9'h079};
			4'd5:    word = {7'd4, 9'h010};
			4'd6:    word = {7'd5, 9'h004};
			4'd7:    word = {7'd6, 9'h000};
			4'd8:    word = {7'd7, 9'h001};
			4'd9:    word = {7'd8, 9'h022};
			4'd10:   word = {7'd9, 9'h001};
			4'd11:   word = {8'h15, 8'h00};	// Video, plain register and data
			default: word = 16'h0000;
		endcase
		if (idx < VIDEO_FIRST)
		begin
			w.devAddr = AUDIO_ADDR;
			w.regAddr = {word[15:9], word[8]};	// Data bit 8 folds into bit 0
			w.regData = word[7:0];
		end
		else
		begin
			w.devAddr = VIDEO_ADDR;
			w.regAddr = word[15:8];
			w.regData = word[7:0];
		end
		return w;
	endfunction

	// Compare one finished transfer, then step the schedule
	task automatic checkTransfer();
		xferCount = xferCount + 1;
		if (bitCnt != 28)	// 27 bit clocks plus the rise ahead of stop
		begin
			errCount = errCount + 1;
			$display("Bus transfer %0d had %0d SCL pulses instead of 27", xferCount, bitCnt - 1);
		end
		else
		begin
			expWrite = refWrite(curIdx);
			if (dataShift !== expWrite)
			begin
				errCount = errCount + 1;
				$display("[ERROR] busWrite idx %0d try %0d: expected %h, actual %h",
					curIdx, curTry, expWrite, dataShift);
			end
			if (ackHigh !== nackNow)
			begin
				errCount = errCount + 1;
				$display("[ERROR] busNack idx %0d try %0d: expected %0b, actual %0b",
					curIdx, curTry, nackNow, ackHigh);
			end
		end
		if (nackNow && !(curIdx == alwaysIdx && curTry == MAX_TRIES - 1))
			curTry = curTry + 1;	// Same entry again
		else
		begin
			curIdx = curIdx + 4'd1;	// Sent or skipped
			curTry = 0;
			if (curIdx == LUT_SIZE)
				runCount = runCount + 1;
		end
	endtask

	////////////////////////////////////////
	// Bus decode, lines stable at falling clock
	always @(negedge iCLK)
	begin
		if (!iRST_N)
		begin
			curIdx    = '0;
			curTry    = 0;
			bitCnt    = 0;
			ackHigh   = 1'b0;
			dataShift = '0;
			prevScl   = 1'b1;
			prevSda   = 1'b1;
			xferCount = 0;
			runCount  = 0;
			errCount  = 0;
		end
		else
		begin
			if (prevScl && scl && prevSda && !sda)
			begin
				bitCnt  = 0;	// Start
				ackHigh = 1'b0;
				if (curIdx == LUT_SIZE)
					curIdx = '0;	// Rerun begins
			end
			else if (prevScl && scl && !prevSda && sda)
				checkTransfer();	// Stop
			else if (!prevScl && scl)
			begin
				if (bitCnt < 27 && bitCnt % 9 == 8)
					ackHigh = ackHigh | sda;
				else if (bitCnt < 27)
					dataShift = {dataShift[22:0], sda};
				bitCnt = bitCnt + 1;
			end
			prevScl = scl;
			prevSda = sda;
		end
	end

endmodule

// File: codecCfgPkg.sv
package codecCfgPkg;

	//////////////// Bus timing ////////////////
	localparam int CLK_FREQ    = 50_000_000;	// System clock in Hz
	localparam int I2C_FREQ    = 400_000;		// SCL bit rate in Hz
	// Four quarters per SCL period
	localparam int QUARTER_DIV = CLK_FREQ / (I2C_FREQ * 4);	// 31 cycles

	//////////////// Write table ////////////////
	localparam int LUT_SIZE    = 12;		// Audio entries plus one video entry
	localparam int VIDEO_FIRST = 11;		// First video decoder index
	localparam logic [7:0] AUDIO_ADDR = 8'h34;	// Audio codec write address
	localparam logic [7:0] VIDEO_ADDR = 8'h40;	// Video decoder write address
	localparam int MAX_TRIES   = 3;		// Attempts before an entry is skipped

	// Wishbone word addresses
	localparam logic [1:0] REG_STATUS  = 2'd0;
	localparam logic [1:0] REG_CONTROL = 2'd1;

	//////////////// Structs ////////////////
	// One register write as sent on the bus
	typedef struct packed
	{
		logic [7:0] devAddr;	// Byte 1
		logic [7:0] regAddr;	// Byte 2
		logic [7:0] regData;	// Byte 3
	} cfgWrite_t;

	// Transfer outcome from the bit engine
	typedef struct packed
	{
		logic done;	// One-cycle pulse after stop
		logic nack;	// Valid with done
	} i2cResult_t;

	// Wishbone classic request from the host
	typedef struct packed
	{
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  adr;	// Word address
		logic [31:0] dat;	// Write data
	} wbReq_t;

	// Wishbone classic response
	typedef struct packed
	{
		logic        ack;
		logic [31:0] dat;	// Read data
	} wbRsp_t;

	//////////////// State enums ////////////////
	typedef enum logic [2:0]
	{
		SEQ_IDLE,	// Just out of reset
		SEQ_LOAD,	// Fetch entry and start transfer
		SEQ_XFER,	// Wait for transfer result
		SEQ_NEXT,	// Step to next entry
		SEQ_DONE	// Table finished
	} seqState_e;

	typedef enum logic [2:0]
	{
		PH_IDLE,	// Bus released
		PH_START,	// Start condition
		PH_BIT,		// Data bit of current byte
		PH_ACK,		// Acknowledge slot
		PH_STOP		// Stop condition
	} i2cPhase_e;

endpackage

// File: codecCfgTb.sv
module codecCfgTb;
	timeunit 1ns;
	timeprecision 1ps;
	import codecCfgPkg::*;

	logic       iCLK = 1'b0;
	logic       iRST_N;
	wbReq_t     wbIn;
	wbRsp_t     wbOut;
	logic       i2cScl;
	wire        i2cSda;
	logic       slaveLow = 1'b0;	// Slave model pulls SDA
	int         slaveBits = 0;	// SCL rises since start
	logic       nackNow;
	logic [3:0] onceIdx;
	logic [3:0] alwaysIdx;
	int         xferCount;
	int         runCount;
	int         busErrs;
	int         errCount = 0;
	logic       timedOut = 1'b0;
	logic [31:0] st;

	always #5 iCLK = ~iCLK;	// 100 MHz testbench clock

	pullup (i2cSda);
	assign i2cSda = slaveLow ? 1'b0 : 1'bz;

	codecCfgTop UUT
	(
		.iCLK   (iCLK),
		.iRST_N (iRST_N),
		.wbIn   (wbIn),
		.wbOut  (wbOut),
		.i2cScl (i2cScl),
		.i2cSda (i2cSda)
	);

	codecCfgCheck uCheck
	(
		.iCLK      (iCLK),
		.iRST_N    (iRST_N),
		.scl       (i2cScl),
		.sda       (i2cSda),
		.onceIdx   (onceIdx),
		.alwaysIdx (alwaysIdx),
		.nackNow   (nackNow),
		.xferCount (xferCount),
		.runCount  (runCount),
		.errCount  (busErrs)
	);

	bind codecCfgTop codecCfgAssert uAssert
	(
		.iCLK     (iCLK),
		.iRST_N   (iRST_N),
		.scl      (i2cScl),
		.sda      (i2cSda),
		.busPhase (uMaster.phase),
		.wbIn     (wbIn),
		.wbOut    (wbOut)
	);

	////////////////////////////////////////
	// I2C slave model
	always @(negedge i2cSda)
		if (i2cScl)
			slaveBits = 0;	// Start
	always @(posedge i2cScl)
		slaveBits = slaveBits + 1;
	always @(negedge i2cScl)
	begin
		if (slaveBits % 9 == 8)
			slaveLow = !(slaveBits == 8 && nackNow);	// NACK address byte on schedule
		else
			slaveLow = 1'b0;
	end

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [3:0] pickIndex(logic [3:0] avoid);
		logic [15:0] s;
		logic [3:0]  v;
		s = 16'd47348;
		for (int n = 0; n < 16; n++)
		begin
			v = '0;
			for (int b = 0; b < 4; b++)
			begin
				s = lfsrStep(s);	// One step per bit
				v = {v[2:0], s[0]};
			end
			if (v < LUT_SIZE && v != avoid)
				return v;
		end
		return 4'((avoid + 1) % LUT_SIZE);
	endfunction

	// Transfers per run from the NACK schedule
	function automatic int xfersPerRun();
		return LUT_SIZE + 1 + (MAX_TRIES - 1);
	endfunction

	task automatic compareValue(string name, int expVal, int actVal);
		if (expVal != actVal)
		begin
			errCount = errCount + 1;
			$display("[ERROR] %s: expected %0d, actual %0d", name, expVal, actVal);
		end
	endtask

	////////////////////////////////////////
	// Wishbone host
	task automatic busAccess(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int waitCnt;
		@(posedge iCLK);
		#1;
		wbIn.cyc = 1'b1;
		wbIn.stb = 1'b1;
		wbIn.we  = we;
		wbIn.adr = adr;
		wbIn.dat = wdata;
		waitCnt  = 0;
		do
		begin
			@(posedge iCLK);
			#1;
			waitCnt = waitCnt + 1;
		end
		while (!wbOut.ack && waitCnt < 20);
		if (!wbOut.ack)
		begin
			timedOut = 1'b1;
			$display("No Wishbone ack within 20 cycles");
		end
		rdata = wbOut.dat;
		wbIn  = '0;	// stb drops before the next access
	endtask

	task automatic waitDone(output logic [31:0] stat);
		int polls;
		polls = 0;
		stat  = '0;
		while (!stat[1] && !timedOut && polls < 2000)
		begin
			repeat (200) @(posedge iCLK);
			busAccess(1'b0, REG_STATUS, 32'h0, stat);
			polls = polls + 1;
		end
		if (!stat[1] && !timedOut)
		begin
			timedOut = 1'b1;
			$display("Run did not finish within 2000 status polls");
		end
	endtask

	// Poll status until the sequencer has reached a table position
	task automatic waitIndex(input logic [3:0] target, output logic [31:0] stat);
		int polls;
		polls = 0;
		stat  = '0;
		while (stat[7:4] < target && !timedOut && polls < 2000)
		begin
			repeat (50) @(posedge iCLK);
			busAccess(1'b0, REG_STATUS, 32'h0, stat);
			polls = polls + 1;
		end
		if (stat[7:4] < target && !timedOut)
		begin
			timedOut = 1'b1;
			$display("Index %0d not reached within 2000 status polls", target);
		end
	endtask

	task automatic checkFinal(string name, logic [31:0] stat, int runs);
		compareValue({name, "Busy"}, 0, stat[0]);
		compareValue({name, "Done"}, 1, stat[1]);
		compareValue({name, "Index"}, LUT_SIZE, stat[7:4]);
		compareValue({name, "NackCount"}, 1 + MAX_TRIES, stat[15:8]);
		compareValue({name, "FailCount"}, 1, stat[23:16]);
		compareValue({name, "Runs"}, runs, runCount);
		compareValue({name, "Transfers"}, runs * xfersPerRun(), xferCount);
	endtask

	////////////////////////////////////////
	// Test sequence
	task automatic runChecks();
		busAccess(1'b0, REG_STATUS, 32'h0, st);	// Early in run 1
		compareValue("runBusy", 1, st[0]);
		compareValue("runDone", 0, st[1]);
		waitIndex(alwaysIdx + 4'd1, st);	// Past the skipped entry
		if (timedOut)
			return;
		compareValue("midRunBusy", 1, st[0]);
		busAccess(1'b1, REG_CONTROL, 32'h1, st);	// Ignored while busy
		waitDone(st);
		if (timedOut)
			return;
		checkFinal("firstRun", st, 1);
		busAccess(1'b1, REG_CONTROL, 32'h1, st);	// Accepted after done
		busAccess(1'b0, REG_STATUS, 32'h0, st);
		compareValue("rerunBusy", 1, st[0]);
		compareValue("rerunNackClear", 0, st[15:8]);
		compareValue("rerunFailClear", 0, st[23:16]);
		compareValue("rerunIndex", 0, st[7:4]);
		waitDone(st);
		if (timedOut)
			return;
		checkFinal("secondRun", st, 2);
		repeat (2000) @(posedge iCLK);	// Bus must stay quiet
		compareValue("quietAfterDone", 2 * xfersPerRun(), xferCount);
	endtask

	task automatic finishRun();
		$display("Error counts: testbench %0d, bus checker %0d, timeouts %0d",
			errCount, busErrs, timedOut);
		if (errCount == 0 && busErrs == 0 && !timedOut)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	initial
	begin
		wbIn      = '0;
		iRST_N    = 1'b0;
		alwaysIdx = 4'd5;	// Persistent NACK
		onceIdx   = pickIndex(alwaysIdx);
		repeat (4) @(posedge iCLK);
		#1 iRST_N = 1'b1;
		runChecks();
		finishRun();
	end

endmodule

// File: codecCfgTop.sv
module codecCfgTop
(
	input  logic                iCLK,
	input  logic                iRST_N,
	input  codecCfgPkg::wbReq_t wbIn,	// Host side
	output codecCfgPkg::wbRsp_t wbOut,
	output logic                i2cScl,	// I2C side
	inout  wire                 i2cSda
);
	import codecCfgPkg::*;

	logic [3:0] index;
	cfgWrite_t  entry;
	cfgWrite_t  xferData;
	logic       xferStart;
	i2cResult_t result;
	logic       seqBusy;	// Run in progress
	logic       seqDone;
	logic [7:0] nackCount;
	logic [7:0] failCount;
	logic       restart;
	logic       sdaLow;
	logic       sdaIn;

	//////////////// Open-drain SDA ////////////////
	assign i2cSda = sdaLow ? 1'b0 : 1'bz;	// Pull-up gives the high level
	assign sdaIn  = i2cSda;

	//////////////// Blocks ////////////////
	cfgRom uRom
	(
		.index (index),
		.entry (entry)
	);

	cfgSequencer uSeq
	(
		.iCLK      (iCLK),
		.iRST_N    (iRST_N),
		.restart   (restart),
		.entry     (entry),
		.index     (index),
		.xferStart (xferStart),
		.xferData  (xferData),
		.result    (result),
		.busy      (seqBusy),
		.done      (seqDone),
		.nackCount (nackCount),
		.failCount (failCount)
	);

	i2cMaster uMaster
	(
		.iCLK      (iCLK),
		.iRST_N    (iRST_N),
		.xferStart (xferStart),	// Only pulsed from SEQ_LOAD
		.xferData  (xferData),
		.result    (result),
		.busy      (),
		.scl       (i2cScl),
		.sdaLow    (sdaLow),
		.sdaIn     (sdaIn)
	);

	wbCfgRegs uRegs
	(
		.iCLK      (iCLK),
		.iRST_N    (iRST_N),
		.wbIn      (wbIn),
		.wbOut     (wbOut),
		.restart   (restart),
		.busy      (seqBusy),
		.done      (seqDone),
		.index     (index),
		.nackCount (nackCount),
		.failCount (failCount)
	);

endmodule

// File: codecCfg_assert.sv
module codecCfgAssert
(
	input logic                   iCLK,
	input logic                   iRST_N,
	input logic                   scl,
	input logic                   sda,
	input codecCfgPkg::i2cPhase_e busPhase,	// Bit engine phase
	input codecCfgPkg::wbReq_t    wbIn,
	input codecCfgPkg::wbRsp_t    wbOut
);
	timeunit 1ns;
	timeprecision 1ps;
	import codecCfgPkg::*;

	////////////////////////////////////////
	// I2C framing
	sdaWhileSclHigh: assert property (@(posedge iCLK) disable iff (!iRST_N)
		(scl && $past(scl) && (sda != $past(sda))) |-> (busPhase == PH_START || busPhase == PH_STOP))
		else $error("SDA changed with SCL high outside start or stop");

	////////////////////////////////////////
	// Wishbone handshake
	ackSingleCycle: assert property (@(posedge iCLK) disable iff (!iRST_N)
		wbOut.ack |=> !wbOut.ack)
		else $error("Wishbone ack held for two cycles");

	ackAfterRequest: assert property (@(posedge iCLK) disable iff (!iRST_N)
		wbOut.ack |-> $past(wbIn.cyc && wbIn.stb))
		else $error("Wishbone ack without a prior cyc and stb");

endmodule

// File: i2cMaster.sv
module i2cMaster
(
	input  logic                    iCLK,
	input  logic                    iRST_N,
	input  logic                    xferStart,	// Pulse, ignored while busy
	input  codecCfgPkg::cfgWrite_t  xferData,	// Latched at xferStart
	output codecCfgPkg::i2cResult_t result,
	output logic                    busy,
	output logic                    scl,		// Driven push-pull
	output logic                    sdaLow,		// 1 pulls SDA low
	input  logic                    sdaIn		// Level seen on SDA
);
	import codecCfgPkg::*;

	i2cPhase_e phase;
	logic [$clog2(QUARTER_DIV)-1:0] divCnt;	// Quarter bit divider
	logic       tick;		// One cycle per quarter
	logic [1:0] quarter;		// Quarter within bit
	logic [2:0] bitCnt;		// Bit within byte
	logic [1:0] byteCnt;		// Byte within transfer
	logic [23:0] shiftReg;		// Address, register, data
	logic       nackAcc;		// Any ack slot high
	logic       sclNext;
	logic       sdaNext;
	logic       doneR;
	logic       nackR;

	//////////////// Tick divider ////////////////
	assign tick = (phase != PH_IDLE) && (divCnt == QUARTER_DIV - 1);
	assign busy = (phase != PH_IDLE);

	//////////////// Bit engine ////////////////
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			phase   <= PH_IDLE;
			divCnt  <= '0;
			quarter <= '0;
			bitCnt  <= '0;
			byteCnt <= '0;
			nackAcc <= 1'b0;
			doneR   <= 1'b0;
			nackR   <= 1'b0;
		end
		else
		begin
			doneR <= 1'b0;	// Pulse by default
			if (phase == PH_IDLE)
			begin
				divCnt  <= '0;
				quarter <= '0;
				if (xferStart)
				begin
					phase   <= PH_START;
					bitCnt  <= '0;
					byteCnt <= '0;
					nackAcc <= 1'b0;
				end
			end
			else
			begin
				divCnt <= tick ? '0 : divCnt + 1'b1;
				if (tick)
				begin
					quarter <= quarter + 2'd1;	// Wraps every bit
					case (phase)
						PH_START:
						begin
							if (quarter == 2'd3)
								phase <= PH_BIT;
						end
						PH_BIT:
						begin
							if (quarter == 2'd3)
							begin
								bitCnt <= bitCnt + 3'd1;
								if (bitCnt == 3'd7)
									phase <= PH_ACK;	// Byte shifted out
							end
						end
						PH_ACK:
						begin
							if (quarter == 2'd2)
								nackAcc <= nackAcc | sdaIn;	// Sample with SCL high
							if (quarter == 2'd3)
							begin
								byteCnt <= byteCnt + 2'd1;
								phase   <= (byteCnt == 2'd2) ? PH_STOP : PH_BIT;
							end
						end
						PH_STOP:
						begin
							if (quarter == 2'd3)
							begin
								phase <= PH_IDLE;
								doneR <= 1'b1;		// First idle cycle
								nackR <= nackAcc;
							end
						end
						default: phase <= PH_IDLE;
					endcase
				end
			end
		end
	end

	// Payload shifter, MSB first
	always_ff @(posedge iCLK)
	begin
		if (phase == PH_IDLE && xferStart)
			shiftReg <= xferData;
		else if (tick && phase == PH_BIT && quarter == 2'd3)
			shiftReg <= {shiftReg[22:0], 1'b0};	// Next bit during SCL low
	end

	//////////////// Line levels ////////////////
	always_comb
	begin
		sclNext = 1'b1;
		sdaNext = 1'b0;
		case (phase)
			PH_START:
			begin
				sclNext = (quarter != 2'd3);
				sdaNext = (quarter != 2'd0);	// SDA falls with SCL high
			end
			PH_BIT:
			begin
				sclNext = (quarter == 2'd1) || (quarter == 2'd2);
				sdaNext = ~shiftReg[23];
			end
			PH_ACK:
			begin
				sclNext = (quarter == 2'd1) || (quarter == 2'd2);
				sdaNext = 1'b0;			// Slave drives
			end
			PH_STOP:
			begin
				sclNext = (quarter != 2'd0);
				sdaNext = (quarter < 2'd2);	// SDA rises with SCL high
			end
			default:
			begin
				sclNext = 1'b1;
				sdaNext = 1'b0;
			end
		endcase
	end

	// Registered pins, both lag by one cycle
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			scl    <= 1'b1;
			sdaLow <= 1'b0;
		end
		else
		begin
			scl    <= sclNext;
			sdaLow <= sdaNext;
		end
	end

	assign result.done = doneR;
	assign result.nack = nackR;

endmodule

// File: wbCfgRegs.sv
module wbCfgRegs
(
	input  logic                iCLK,
	input  logic                iRST_N,
	input  codecCfgPkg::wbReq_t wbIn,
	output codecCfgPkg::wbRsp_t wbOut,
	output logic                restart,	// One-cycle pulse
	input  logic                busy,
	input  logic                done,
	input  logic [3:0]          index,
	input  logic [7:0]          nackCount,
	input  logic [7:0]          failCount
);
	import codecCfgPkg::*;

	logic        ack;
	logic        served;	// Acked, waiting for stb low
	logic        accept;	// Start of a new access
	logic [31:0] rdData;
	logic [31:0] status;

	//////////////// Decode ////////////////
	assign accept = wbIn.cyc && wbIn.stb && !ack && !served;

	// Status word layout
	assign status = {8'h00, failCount, nackCount, index, 2'b00, done, busy};

	//////////////// Handshake ////////////////
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			ack     <= 1'b0;
			served  <= 1'b0;
			restart <= 1'b0;
		end
		else
		begin
			ack <= accept;	// One cycle late, one cycle long
			if (wbIn.cyc && wbIn.stb)
				served <= served | accept;
			else
				served <= 1'b0;		// stb dropped
			restart <= accept && wbIn.we && (wbIn.adr == REG_CONTROL) && wbIn.dat[0];
		end
	end

	// Read data captured with the ack
	always_ff @(posedge iCLK)
	begin
		if (accept)
		begin
			case (wbIn.adr)
				REG_STATUS:  rdData <= status;
				REG_CONTROL: rdData <= 32'h0;	// Restart bit self-clears
				default:     rdData <= 32'h0;
			endcase
		end
	end

	assign wbOut.ack = ack;
	assign wbOut.dat = rdData;

endmodule
